//--- sim.f
+incdir+src
src/sump_pkg.sv
src/sump_cmd_decoder.sv
src/sump_trigger_stage.sv
src/sump_trigger_level.sv
src/sump_capture_out.sv
src/sump_trigger_top.sv
test/tb_clk_gen.sv
test/tb_sump_trigger.sv

//--- Bender.yml
package:
  name: sump_trigger

export_include_dirs:
  - src

sources:
  - src/sump_pkg.sv
  - src/sump_cmd_decoder.sv
  - src/sump_trigger_stage.sv
  - src/sump_trigger_level.sv
  - src/sump_capture_out.sv
  - src/sump_trigger_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_sump_trigger.sv

//--- test/tb_sump_trigger.sv
// --------------------
// sump trigger testbench
// directed tests for match, delay, staging, serial, soft reset
// --------------------
`timescale 1ns/10ps
`include "sump_defines.svh"

module tb_sump_trigger import sump_pkg::*; ();

  logic                     clk_i;
  logic                     rst_in;
  logic                     cmd_vld_i;
  sump_opcode_e             opcode_i;
  sump_cmd_u                cmd_i;
  logic                     stb_i;
  logic [`SUMP_SMPL_W-1:0]  smpls_i;
  logic                     armed_o;
  logic                     trig_o;
  logic                     triggered_o;
  logic [`SUMP_SMPL_W-1:0]  trig_smpl_o;
  logic [`SUMP_LVL_W-1:0]   lvl_o;

  integer seed = 32'h3a39;   // filler samples
  int     test_errs;
  int     tests_ok;
  int     tests_bad;
  string  test_name;

  tb_clk_gen tb_clk_gen_inst (.clk_o(clk_i), .rst_no(rst_in));

  sump_trigger_top sump_trigger_top_inst (.*);

  // stage config word with the delay big endian over bytes 2..3
  function automatic sump_cmd_u cfg_word(input logic [`SUMP_DLY_W-1:0] dly,
                                         input logic [`SUMP_LVL_W-1:0] lvl,
                                         input logic [4:0] chl, input logic ser,
                                         input logic act);
    sump_cmd_u c;
    c.raw        = '0;
    c.cfg.dly_hi = dly[15:8];
    c.cfg.dly_lo = dly[7:0];
    c.cfg.lvl    = lvl;
    c.cfg.chl_hi = chl[4];
    c.cfg.chl_lo = chl[3:0];
    c.cfg.ser    = ser;
    c.cfg.act    = act;
    return c;
  endfunction

  // random sample with every masked bit forced opposite to the value
  function automatic logic [31:0] nomatch_fill(input logic [31:0] mask, input logic [31:0] val);
    logic [31:0] r;
    r = $random(seed);
    return (r & ~mask) | (~val & mask);
  endfunction

  task automatic send_cmd(input sump_opcode_e op, input logic [31:0] word);
    @(posedge clk_i);
    cmd_vld_i <= 1'b1;
    opcode_i  <= op;
    cmd_i     <= word;
    @(posedge clk_i);
    cmd_vld_i <= 1'b0;
    repeat (2) @(posedge clk_i);   // set strobe then stage register update
    @(negedge clk_i);
  endtask

  task automatic load_stage(input int n, input logic [31:0] mask, input logic [31:0] val,
                            input sump_cmd_u cfg);
    logic [7:0] base;
    base = 8'hC0 + {n[3:0], 2'b00};   // 4 opcodes per stage
    send_cmd(sump_opcode_e'(base), mask);
    send_cmd(sump_opcode_e'(base + 8'd1), val);
    send_cmd(sump_opcode_e'(base + 8'd2), cfg.raw);
  endtask

  task automatic send_smpl(input logic [31:0] s);
    @(posedge clk_i);
    stb_i   <= 1'b1;
    smpls_i <= s;
    @(posedge clk_i);
    stb_i   <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_trig(output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < 50) begin
      @(negedge clk_i);
      seen = trig_o;
      n++;
    end
  endtask

  task automatic check_smpl(input string name, input logic [`SUMP_SMPL_W-1:0] got,
                            input logic [`SUMP_SMPL_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_lvl(input string name, input logic [`SUMP_LVL_W-1:0] got,
                           input logic [`SUMP_LVL_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic expect_trig(input logic [31:0] exp_smpl);
    logic seen;
    wait_trig(seen);
    if (!seen) begin
      $display("%s: trig_o did not pulse within 50 cycles", test_name);
      test_errs++;
    end else begin
      check_flag("triggered_o", triggered_o, 1'b1);
      check_smpl("trig_smpl_o", trig_smpl_o, exp_smpl);
      @(negedge clk_i);
      check_flag("trig_o", trig_o, 1'b0);   // one cycle only
    end
  endtask

  task automatic expect_quiet();
    logic seen;
    wait_trig(seen);
    if (seen) begin
      $display("%s: trig_o pulsed although no stage may fire", test_name);
      test_errs++;
    end
    check_flag("triggered_o", triggered_o, 1'b0);
  endtask

  // every test starts from a soft reset with all masks zero
  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
    send_cmd(OP_RESET, '0);
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("%s: ok", test_name);
      tests_ok++;
    end else begin
      $display("%s: %0d check(s) wrong", test_name, test_errs);
      tests_bad++;
    end
  endtask

  task automatic parallel_match();
    begin_test("parallel_match");
    load_stage(0, 32'h0000_F0F0, 32'h0000_A050, cfg_word(16'd0, 2'd0, 5'd0, 1'b0, 1'b1));
    send_cmd(OP_ARM, '0);
    check_flag("armed_o", armed_o, 1'b1);
    repeat (2) send_smpl(nomatch_fill(32'h0000_F0F0, 32'h0000_A050));
    send_smpl(32'h3C91_A25B);   // nibbles 3 and 1 match
    expect_trig(32'h3C91_A25B);
    end_test();
  endtask

  task automatic no_false_trigger();
    begin_test("no_false_trigger");
    load_stage(0, 32'hFF00_0000, 32'h7E00_0000, cfg_word(16'd0, 2'd0, 5'd0, 1'b0, 1'b1));
    send_cmd(OP_ARM, '0);
    repeat (8) send_smpl(nomatch_fill(32'hFF00_0000, 32'h7E00_0000));
    expect_quiet();
    check_lvl("lvl_o", lvl_o, 2'd0);
    send_cmd(OP_RESET, '0);   // all stages back to zero mask and no act
    send_cmd(OP_ARM, '0);
    repeat (8) send_smpl($random(seed));
    expect_quiet();
    check_lvl("lvl_o", lvl_o, 2'd0);
    end_test();
  endtask

  task automatic delayed_trigger();
    logic [31:0] fill [3];
    begin_test("delayed_trigger");
    load_stage(0, 32'h0000_00FF, 32'h0000_00C6, cfg_word(16'd3, 2'd0, 5'd0, 1'b0, 1'b1));
    send_cmd(OP_ARM, '0);
    send_smpl(32'h5555_01C6);
    for (int i = 0; i < 3; i++) begin
      fill[i] = nomatch_fill(32'h0000_00FF, 32'h0000_00C6);
      send_smpl(fill[i]);
      if (i == 1) check_flag("triggered_o", triggered_o, 1'b0);   // still counting
    end
    expect_trig(fill[2]);   // third strobe after the match
    end_test();
  endtask

  task automatic staged_trigger();
    begin_test("staged_trigger");
    load_stage(0, 32'h0000_00FF, 32'h0000_005A, cfg_word(16'd0, 2'd0, 5'd0, 1'b0, 1'b0));
    load_stage(1, 32'h0000_FF00, 32'h0000_A500, cfg_word(16'd0, 2'd1, 5'd0, 1'b0, 1'b1));
    send_cmd(OP_ARM, '0);
    send_smpl(32'h0000_A500);   // stage 1 gated at level 0
    expect_quiet();
    check_lvl("lvl_o", lvl_o, 2'd0);
    send_smpl(32'h0000_005A);
    expect_quiet();   // stage 0 has no act
    check_lvl("lvl_o", lvl_o, 2'd1);
    send_smpl(32'h0000_A500);
    expect_trig(32'h0000_A500);
    check_lvl("lvl_o", lvl_o, 2'd2);
    end_test();
  endtask

  task automatic serial_match();
    logic [31:0] pat;
    logic [31:0] s;
    begin_test("serial_match");
    pat = 32'hC3A5_1E97;
    load_stage(0, 32'hFFFF_FFFF, pat, cfg_word(16'd0, 2'd0, 5'd5, 1'b1, 1'b1));
    for (int i = 31; i > 0; i--) begin
      s    = $random(seed);
      s[5] = pat[i];   // msb first on channel 5
      send_smpl(s);
    end
    send_cmd(OP_ARM, '0);   // armed before the last bit only
    s    = $random(seed);
    s[5] = pat[0];
    send_smpl(s);
    expect_trig(s);
    end_test();
  endtask

  task automatic soft_reset();
    begin_test("soft_reset");
    load_stage(0, 32'h00FF_0000, 32'h0042_0000, cfg_word(16'd0, 2'd0, 5'd0, 1'b0, 1'b1));
    send_cmd(OP_ARM, '0);
    send_smpl(32'h8842_1100);
    expect_trig(32'h8842_1100);
    check_lvl("lvl_o", lvl_o, 2'd1);
    send_cmd(OP_RESET, '0);
    check_flag("armed_o", armed_o, 1'b0);
    check_flag("triggered_o", triggered_o, 1'b0);
    check_lvl("lvl_o", lvl_o, 2'd0);
    send_cmd(OP_ARM, '0);
    send_smpl(32'h8842_1100);   // old pattern but the config is gone
    expect_quiet();
    end_test();
  endtask

  initial begin
    int n;
    cmd_vld_i = 1'b0;
    opcode_i  = OP_RESET;
    cmd_i     = '0;
    stb_i     = 1'b0;
    smpls_i   = '0;
    tests_ok  = 0;
    tests_bad = 0;
    n         = 0;
    while (!rst_in && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!rst_in) begin
      $display("reset stayed asserted, no test was run");
      tests_bad++;
    end else begin
      parallel_match();
      no_false_trigger();
      delayed_trigger();
      staged_trigger();
      serial_match();
      soft_reset();
    end
    $display("tests ok %0d, tests wrong %0d", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- test/tb_clk_gen.sv
// --------------------
// testbench clock and reset
// 10 ns clock, low active reset for 3 cycles
// --------------------
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no   // sync, low active
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;   // 10 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;   // released on the third rising edge
  end

endmodule

//--- src/sump_trigger_top.sv
// --------------------
// sump trigger top
// decoder, stages, level counter, capture
// --------------------
`timescale 1ns/10ps
`include "sump_defines.svh"

module sump_trigger_top import sump_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_in,
  input  logic                       cmd_vld_i,
  input  sump_opcode_e               opcode_i,
  input  sump_cmd_u                  cmd_i,
  input  logic                       stb_i,
  input  logic [`SUMP_SMPL_W-1:0]    smpls_i,
  output logic                       armed_o,
  output logic                       trig_o,
  output logic                       triggered_o,
  output logic [`SUMP_SMPL_W-1:0]    trig_smpl_o,
  output logic [`SUMP_LVL_W-1:0]     lvl_o
);

  sump_stage_set_t [`SUMP_NUM_STAGES-1:0] stage_set;
  sump_cmd_u                              cmd_q;
  logic                                   arm;
  logic                                   clr;
  logic [`SUMP_NUM_STAGES-1:0]            stage_match;
  logic [`SUMP_NUM_STAGES-1:0]            stage_run;
  logic                                   fire;

  sump_cmd_decoder sump_cmd_decoder_inst (
    .clk_i, .rst_in, .cmd_vld_i, .opcode_i, .cmd_i,
    .stage_set_o (stage_set),
    .cmd_o       (cmd_q),
    .arm_o       (arm),
    .clr_o       (clr)
  );

  for (genvar i = 0; i < `SUMP_NUM_STAGES; i++) begin : g_stage
    sump_trigger_stage sump_trigger_stage_inst (
      .clk_i, .rst_in, .stb_i, .smpls_i,
      .cmd_i   (cmd_q),
      .set_i   (stage_set[i]),
      .arm_i   (arm),
      .clr_i   (clr),
      .lvl_i   (lvl_o),
      .match_o (stage_match[i]),
      .run_o   (stage_run[i])
    );
  end

  sump_trigger_level sump_trigger_level_inst (
    .clk_i, .rst_in, .lvl_o,
    .match_i (stage_match),
    .run_i   (stage_run),
    .arm_i   (arm),
    .clr_i   (clr),
    .fire_o  (fire)
  );

  sump_capture_out sump_capture_out_inst (
    .clk_i, .rst_in, .stb_i, .smpls_i,
    .armed_o, .trig_o, .triggered_o, .trig_smpl_o,
    .arm_i   (arm),
    .clr_i   (clr),
    .fire_i  (fire)
  );

endmodule

//--- src/sump_capture_out.sv
// --------------------
// sump capture output
// armed flag and trigger sample latch
// --------------------
`timescale 1ns/10ps
`include "sump_defines.svh"

module sump_capture_out (
  input  logic                       clk_i,
  input  logic                       rst_in,
  input  logic                       arm_i,
  input  logic                       clr_i,
  input  logic                       fire_i,
  input  logic                       stb_i,
  input  logic [`SUMP_SMPL_W-1:0]    smpls_i,
  output logic                       armed_o,
  output logic                       trig_o,        // one cycle pulse
  output logic                       triggered_o,
  output logic [`SUMP_SMPL_W-1:0]    trig_smpl_o
);

  logic [`SUMP_SMPL_W-1:0] last_smpl_q;
  logic                    hit;

  // first fire after arm only, arm or clr this cycle wins
  assign hit = fire_i && armed_o && !triggered_o && !arm_i && !clr_i;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      armed_o     <= 1'b0;
      trig_o      <= 1'b0;
      triggered_o <= 1'b0;
    end else begin
      trig_o <= hit;
      if (clr_i) begin
        armed_o     <= 1'b0;
        triggered_o <= 1'b0;
      end else if (arm_i) begin
        armed_o     <= 1'b1;
        triggered_o <= 1'b0;
      end else if (hit) begin
        triggered_o <= 1'b1;   // held until next arm or clr
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_i) last_smpl_q <= smpls_i;
    if (hit)   trig_smpl_o <= last_smpl_q;   // sample in effect at the trigger
  end

endmodule

//--- src/sump_trigger_level.sv
// --------------------
// sump trigger level
// active level counter and fire pulse
// --------------------
`timescale 1ns/10ps
`include "sump_defines.svh"

module sump_trigger_level (
  input  logic                          clk_i,
  input  logic                          rst_in,
  input  logic [`SUMP_NUM_STAGES-1:0]   match_i,   // one per stage
  input  logic [`SUMP_NUM_STAGES-1:0]   run_i,     // one per stage
  input  logic                          arm_i,
  input  logic                          clr_i,
  output logic [`SUMP_LVL_W-1:0]        lvl_o,     // gates higher stages
  output logic                          fire_o     // one cycle after a run
);

  localparam logic [`SUMP_LVL_W-1:0] LVL_MAX = '1;

  logic any_match;
  logic lvl_sat;

  assign any_match = |match_i;   // coinciding matches count once
  assign lvl_sat   = (lvl_o == LVL_MAX);

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      lvl_o <= '0;
    end else if (arm_i || clr_i) begin
      lvl_o <= '0;   // every arm restarts at level 0
    end else if (any_match && !lvl_sat) begin
      lvl_o <= lvl_o + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      fire_o <= 1'b0;
    end else begin
      fire_o <= |run_i;
    end
  end

endmodule

//--- src/sump_trigger_stage.sv
// --------------------
// sump trigger stage
// masked compare, serial shift, delay fsm
// --------------------
`timescale 1ns/10ps
`include "sump_defines.svh"

module sump_trigger_stage import sump_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_in,
  input  sump_cmd_u                  cmd_i,     // registered command word
  input  sump_stage_set_t            set_i,     // this stage's set strobes
  input  logic                       arm_i,
  input  logic                       clr_i,     // soft reset
  input  logic                       stb_i,     // new sample
  input  logic [`SUMP_SMPL_W-1:0]    smpls_i,
  input  logic [`SUMP_LVL_W-1:0]     lvl_i,     // active level
  output logic                       match_o,   // comb pulse, raises level
  output logic                       run_o      // comb pulse, starts capture
);

  typedef enum logic [1:0] {IDLE, ARMD, MTCHD} state_e;

  state_e                    state_q;
  state_e                    state_d;
  logic [`SUMP_DLY_W-1:0]    cnt_q;
  logic [`SUMP_DLY_W-1:0]    cnt_d;

  logic [`SUMP_SMPL_W-1:0]   mask_q;
  logic [`SUMP_SMPL_W-1:0]   val_q;
  logic [`SUMP_DLY_W-1:0]    dly_q;
  logic [`SUMP_LVL_W-1:0]    lvl_q;
  logic [4:0]                chl_q;
  logic                      ser_q;
  logic                      act_q;

  logic [`SUMP_SMPL_W-1:0]   shft_q;
  logic [`SUMP_SMPL_W-1:0]   shft_next;   // includes the bit of this strobe
  logic [`SUMP_SMPL_W-1:0]   comp_vec;
  logic                      trg_hit;

  assign shft_next = {shft_q[`SUMP_SMPL_W-2:0], smpls_i[chl_q]};
  assign comp_vec  = ser_q ? shft_next : smpls_i;
  assign trg_hit   = ~|((comp_vec ^ val_q) & mask_q);  // zero mask always hits

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    match_o = 1'b0;
    run_o   = 1'b0;
    case (state_q)
      IDLE: ;   // wait for arm
      ARMD: begin
        if (stb_i && trg_hit && (lvl_i >= lvl_q)) begin
          state_d = MTCHD;
          cnt_d   = '0;
        end
      end
      MTCHD: begin
        if (cnt_q == dly_q) begin
          state_d = IDLE;
          match_o = |mask_q;   // an "any" stage does not raise the level
          run_o   = act_q;
        end else if (stb_i) begin
          cnt_d = cnt_q + 1'b1;   // counts strobes, not clocks
        end
      end
      default: state_d = IDLE;
    endcase
    if (arm_i) state_d = ARMD;   // re-arm from any state
    if (clr_i) state_d = IDLE;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // serial history of the selected channel
  always_ff @(posedge clk_i) begin
    if (stb_i) shft_q <= shft_next;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in || clr_i) begin
      mask_q <= '0;
      val_q  <= '0;
      dly_q  <= '0;
      lvl_q  <= '0;
      chl_q  <= '0;
      ser_q  <= 1'b0;
      act_q  <= 1'b0;
    end else begin
      if (set_i.set_mask) mask_q <= cmd_i.raw;
      if (set_i.set_val)  val_q  <= cmd_i.raw;
      if (set_i.set_cfg) begin
        dly_q <= {cmd_i.cfg.dly_hi, cmd_i.cfg.dly_lo};
        lvl_q <= cmd_i.cfg.lvl;
        chl_q <= {cmd_i.cfg.chl_hi, cmd_i.cfg.chl_lo};
        ser_q <= cmd_i.cfg.ser;
        act_q <= cmd_i.cfg.act;
      end
    end
  end

endmodule

//--- src/sump_cmd_decoder.sv
// --------------------
// sump command decoder
// opcode to per stage set strobes, arm and clr
// --------------------
`timescale 1ns/10ps
`include "sump_defines.svh"

module sump_cmd_decoder import sump_pkg::*; (
  input  logic                                    clk_i,
  input  logic                                    rst_in,       // sync, low active
  input  logic                                    cmd_vld_i,    // one cycle strobe
  input  sump_opcode_e                            opcode_i,
  input  sump_cmd_u                               cmd_i,
  output sump_stage_set_t [`SUMP_NUM_STAGES-1:0]  stage_set_o,  // registered, one hot
  output sump_cmd_u                               cmd_o,        // command word for the stages
  output logic                                    arm_o,
  output logic                                    clr_o
);

  logic [7:0]                              op_raw;
  logic                                    is_trg_op;   // 0xc? range
  logic [1:0]                              stg_idx;
  logic [1:0]                              sub_fn;
  sump_stage_set_t [`SUMP_NUM_STAGES-1:0]  set_d;

  assign op_raw    = opcode_i;
  assign is_trg_op = (op_raw[7:4] == 4'hC);
  assign stg_idx   = op_raw[3:2];
  assign sub_fn    = op_raw[1:0];   // 0 mask, 1 value, 2 config, 3 unused

  always_comb begin
    set_d = '0;
    if (cmd_vld_i && is_trg_op) begin
      // indices past the stage count find no slot
      for (int i = 0; i < `SUMP_NUM_STAGES; i++) begin
        if (int'(stg_idx) == i) begin
          case (sub_fn)
            2'd0:    set_d[i].set_mask = 1'b1;
            2'd1:    set_d[i].set_val  = 1'b1;
            2'd2:    set_d[i].set_cfg  = 1'b1;
            default: set_d[i]          = '0;
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      stage_set_o <= '0;
      arm_o       <= 1'b0;
      clr_o       <= 1'b0;
    end else begin
      stage_set_o <= set_d;
      arm_o       <= cmd_vld_i && (opcode_i == OP_ARM);
      clr_o       <= cmd_vld_i && (opcode_i == OP_RESET);
    end
  end

  // word travels one cycle with its strobe
  always_ff @(posedge clk_i) begin
    if (cmd_vld_i) cmd_o <= cmd_i;
  end

endmodule

//--- src/sump_pkg.sv
// --------------------
// sump trigger types
// opcodes, command word views, strobes
// --------------------
package sump_pkg;

  // host opcodes, stage n sits at 0xc0 + 4*n
  typedef enum logic [7:0] {
    OP_RESET      = 8'h00,
    OP_ARM        = 8'h01,
    OP_SET_MASK_0 = 8'hC0,
    OP_SET_VAL_0  = 8'hC1,
    OP_SET_CFG_0  = 8'hC2,
    OP_SET_MASK_1 = 8'hC4,
    OP_SET_VAL_1  = 8'hC5,
    OP_SET_CFG_1  = 8'hC6,
    OP_SET_MASK_2 = 8'hC8,
    OP_SET_VAL_2  = 8'hC9,
    OP_SET_CFG_2  = 8'hCA,
    OP_SET_MASK_3 = 8'hCC,
    OP_SET_VAL_3  = 8'hCD,
    OP_SET_CFG_3  = 8'hCE
  } sump_opcode_e;

  // stage configuration, byte 0 is the lsbyte of the command word
  typedef struct packed {
    logic [7:0] dly_lo;   // byte 3, delay is big endian over bytes 2..3
    logic [7:0] dly_hi;   // byte 2
    logic [3:0] chl_lo;   // byte 1, low channel bits
    logic [1:0] pad_1;
    logic [1:0] lvl;      // byte 1 [1:0]
    logic [3:0] pad_0;
    logic       act;      // start capture when this stage runs
    logic       ser;      // serial compare on one channel
    logic       pad_0b;
    logic       chl_hi;   // channel msb
  } sump_stage_cfg_t;

  // one command word, raw mask/value or stage config
  typedef union packed {
    logic [31:0]     raw;
    sump_stage_cfg_t cfg;
  } sump_cmd_u;

  // set strobes of one stage
  typedef struct packed {
    logic set_mask;
    logic set_val;
    logic set_cfg;
  } sump_stage_set_t;

endpackage

//--- src/sump_defines.svh
// --------------------
// sump trigger sizes
// shared by all trigger blocks
// --------------------
`ifndef SUMP_DEFINES_SVH
`define SUMP_DEFINES_SVH

// stage count, at most 4 since the opcode holds a 2 bit index
`define SUMP_NUM_STAGES 4

`define SUMP_SMPL_W 32  // sampled channels per strobe

// delay counter per stage
`define SUMP_DLY_W 16

`define SUMP_LVL_W 2  // trigger level, saturates at 3

`endif
